// File: Bender.yml
package:
  name: wg_encap

sources:
  - include_dirs:
      - design
    files:
      - design/wg_encap_pkg.sv
      - design/wg_peer_table.sv
      - design/wg_ingress.sv
      - design/wg_framer.sv
      - design/wg_egress.sv
      - design/wg_encap.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/wg_encap_tb.sv

// File: design/wg_egress.sv
`include "wg_encap_settings.svh"

module wg_egress (
   input  logic                  inp,
   input  logic                  reset,
   input  logic                  fr_valid,
   output logic                  fr_ready,
   input  logic [`WG_DATA_W-1:0] fr_data,
   input  logic [`WG_KEEP_W-1:0] fr_keep,
   input  logic                  fr_last,
   input  logic                  busy,
   output logic                  out_valid,
   input  logic                  out_ready,
   output logic [`WG_DATA_W-1:0] out_data,
   output logic [`WG_KEEP_W-1:0] out_keep,
   output logic                  out_last,
   output logic                  idle
);

   logic                  skid_valid;
   logic [`WG_DATA_W-1:0] skid_data;
   logic [`WG_KEEP_W-1:0] skid_keep;
   logic                  skid_last;

   // Ready toward the framer comes from a register, cutting the path
   assign fr_ready  = ~skid_valid;
   assign out_valid = skid_valid | fr_valid;
   assign out_data  = skid_valid ? skid_data : fr_data;
   assign out_keep  = skid_valid ? skid_keep : fr_keep;
   assign out_last  = skid_valid ? skid_last : fr_last;
   assign idle      = ~busy & ~skid_valid;

   always_ff @(posedge inp) begin
      if (reset) begin
         skid_valid <= 1'b0;
      end else if (skid_valid) begin
         skid_valid <= ~out_ready;
      end else begin
         skid_valid <= fr_valid & ~out_ready;
      end
   end

   // Catch the pass-through beat when the output stalls
   always_ff @(posedge inp) begin
      if (!skid_valid) begin
         skid_data <= fr_data;
         skid_keep <= fr_keep;
         skid_last <= fr_last;
      end
   end

   a_stall_stable: assert property (@(posedge inp) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)));

endmodule

// File: design/wg_encap.sv
`include "wg_encap_settings.svh"

module wg_encap (
   input  logic                      inp,
   input  logic                      reset,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  wg_encap_pkg::beat_t       in_data,
   input  logic [`WG_KEEP_W-1:0]     in_keep,
   input  logic                      in_last,
   input  logic [`WG_PEER_IDX_W-1:0] in_peer,
   input  logic                      in_bypass,
   output logic                      out_valid,
   input  logic                      out_ready,
   output wg_encap_pkg::beat_t       out_data,
   output logic [`WG_KEEP_W-1:0]     out_keep,
   output logic                      out_last,
   input  logic                      cfg_write,
   input  logic [`WG_PEER_IDX_W-1:0] cfg_peer,
   input  logic [47:0]               cfg_local_mac,
   input  logic [47:0]               cfg_remote_mac,
   input  logic [31:0]               cfg_local_ip,
   input  logic [31:0]               cfg_remote_ip,
   input  logic [15:0]               cfg_local_port,
   input  logic [15:0]               cfg_remote_port,
   input  logic [31:0]               cfg_remote_id,
   input  logic [63:0]               cfg_send_cnt,
   output logic                      idle
);
   import wg_encap_pkg::*;

   // Ingress to framer
   logic                      ing_valid;
   logic                      ing_ready;
   beat_t                     ing_data;
   logic [`WG_KEEP_W-1:0]     ing_keep;
   logic                      ing_last;
   logic                      ing_sop;
   logic [`WG_PEER_IDX_W-1:0] ing_peer;
   logic                      ing_bypass;

   // Framer and peer table
   logic                      lookup_req;
   logic [`WG_PEER_IDX_W-1:0] lookup_peer;
   logic                      count_advance;
   logic [`WG_PEER_IDX_W-1:0] count_peer;
   logic [47:0]               local_mac;
   logic [47:0]               remote_mac;
   logic [31:0]               local_ip;
   logic [31:0]               remote_ip;
   logic [15:0]               local_port;
   logic [15:0]               remote_port;
   logic [31:0]               remote_id;
   logic [63:0]               send_cnt;

   // Framer to egress
   logic                      fr_valid;
   logic                      fr_ready;
   beat_t                     fr_data;
   logic [`WG_KEEP_W-1:0]     fr_keep;
   logic                      fr_last;
   logic                      busy;

   wg_ingress    wg_ingress_i    (.*);
   wg_framer     wg_framer_i     (.*);
   wg_peer_table wg_peer_table_i (.*);
   wg_egress     wg_egress_i     (.*);

endmodule

// File: design/wg_encap_pkg.sv
`include "wg_encap_settings.svh"

package wg_encap_pkg;

   // One stream beat, byte 0 sits in bits 7:0
   typedef logic [`WG_DATA_W-1:0] beat_t;

   // First beat of an inner packet
   // Raw view goes out as payload, header view yields the inner length
   typedef union packed {
      beat_t raw;
      struct packed {
         logic [`WG_DATA_W-49:0] rest;
         logic [15:0]            ident;
         logic [15:0]            total_len;  // big-endian on the wire
         logic [7:0]             dscp;
         logic [7:0]             ver_ihl;
      } hdr;
   } first_beat_u;

endpackage

// File: design/wg_encap_settings.svh
`ifndef WG_ENCAP_SETTINGS_SVH
`define WG_ENCAP_SETTINGS_SVH

// ----------------------------------------------------------------------
// Datapath and peer table sizes
// ----------------------------------------------------------------------
`define WG_DATA_W        128
`define WG_KEEP_W        16
`define WG_PEER_CNT      8
`define WG_PEER_IDX_W    3

// ----------------------------------------------------------------------
// Fixed header field values
// ----------------------------------------------------------------------
`define WG_IP_TTL        64
`define WG_IP_PROTO_UDP  17
`define WG_MSG_TYPE_DATA 4
`define WG_ETH_TYPE_IPV4 16'h0800

// ----------------------------------------------------------------------
// Header byte counts
// ----------------------------------------------------------------------
`define WG_IP_HDR_BYTES  20
`define WG_UDP_HDR_BYTES 8
`define WG_WG_HDR_BYTES  16

// Header bytes left over in beat 3, ahead of the first payload bytes
`define WG_TAIL_BYTES    10

`endif

// File: design/wg_framer.sv
`include "wg_encap_settings.svh"

module wg_framer (
   input  logic                      inp,
   input  logic                      reset,
   input  logic                      ing_valid,
   output logic                      ing_ready,
   input  wg_encap_pkg::beat_t       ing_data,
   input  logic [`WG_KEEP_W-1:0]     ing_keep,
   input  logic                      ing_last,
   input  logic                      ing_sop,
   input  logic [`WG_PEER_IDX_W-1:0] ing_peer,
   input  logic                      ing_bypass,
   output logic                      lookup_req,
   output logic [`WG_PEER_IDX_W-1:0] lookup_peer,
   input  logic [47:0]               local_mac,
   input  logic [47:0]               remote_mac,
   input  logic [31:0]               local_ip,
   input  logic [31:0]               remote_ip,
   input  logic [15:0]               local_port,
   input  logic [15:0]               remote_port,
   input  logic [31:0]               remote_id,
   input  logic [63:0]               send_cnt,
   output logic                      count_advance,
   output logic [`WG_PEER_IDX_W-1:0] count_peer,
   output logic                      fr_valid,
   input  logic                      fr_ready,
   output wg_encap_pkg::beat_t       fr_data,
   output logic [`WG_KEEP_W-1:0]     fr_keep,
   output logic                      fr_last,
   output logic                      busy
);
   import wg_encap_pkg::*;

   // Header states are consecutive so they can simply count up
   localparam logic [3:0] st_idle    = 4'd0;
   localparam logic [3:0] st_bypass  = 4'd1;
   localparam logic [3:0] st_lookup  = 4'd2;
   localparam logic [3:0] st_hdr0    = 4'd3;
   localparam logic [3:0] st_hdr1    = 4'd4;
   localparam logic [3:0] st_hdr2    = 4'd5;
   localparam logic [3:0] st_hdr3    = 4'd6;
   localparam logic [3:0] st_payload = 4'd7;
   localparam logic [3:0] st_flush   = 4'd8;

   // Input bytes that close out each payload beat
   localparam int head_bytes = `WG_KEEP_W - `WG_TAIL_BYTES;
   localparam int split      = 8 * head_bytes;

   localparam logic [15:0] eth_type  = `WG_ETH_TYPE_IPV4;
   localparam logic [15:0] ip_extra  = `WG_IP_HDR_BYTES + `WG_UDP_HDR_BYTES + `WG_WG_HDR_BYTES;
   localparam logic [15:0] udp_extra = `WG_UDP_HDR_BYTES + `WG_WG_HDR_BYTES;
   localparam logic [7:0]  ip_ttl    = `WG_IP_TTL;
   localparam logic [7:0]  ip_proto  = `WG_IP_PROTO_UDP;
   localparam logic [31:0] msg_type  = `WG_MSG_TYPE_DATA;

   logic [3:0]                state;
   first_beat_u               first_w;
   beat_t                     hold_q;
   logic [`WG_KEEP_W-1:0]     keep_q;
   logic [15:0]               inner_len_q;
   logic [`WG_PEER_IDX_W-1:0] peer_q;
   logic [15:0]               ip_len;
   logic [15:0]               udp_len;
   logic                      in_hs;
   logic                      fr_hs;

   assign first_w.raw = ing_data;
   assign ip_len      = inner_len_q + ip_extra;
   assign udp_len     = inner_len_q + udp_extra;
   assign in_hs       = ing_valid & ing_ready;
   assign fr_hs       = fr_valid & fr_ready;

   assign lookup_req    = (state == st_idle) & ing_valid & ing_sop & ~ing_bypass;
   assign lookup_peer   = ing_peer;
   assign count_peer    = peer_q;
   assign count_advance = fr_hs & fr_last & ((state == st_payload) | (state == st_flush));
   assign busy          = (state != st_idle) | ing_valid;

   // ----------------------------------------------------------------------
   // Packet state
   // ----------------------------------------------------------------------
   always_ff @(posedge inp) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (in_hs && ing_sop) begin
                  if (!ing_bypass) begin
                     state <= st_lookup;
                  end else if (!ing_last) begin
                     state <= st_bypass;
                  end
               end
            end
            st_bypass: begin
               if (in_hs && ing_last) begin
                  state <= st_idle;
               end
            end
            st_lookup: state <= st_hdr0;
            st_hdr0, st_hdr1, st_hdr2, st_hdr3: begin
               if (fr_ready) begin
                  state <= state + 4'd1;
               end
            end
            st_payload: begin
               // Bytes past the first six spill into one more beat
               if (in_hs && ing_last) begin
                  state <= ing_keep[head_bytes] ? st_flush : st_idle;
               end
            end
            st_flush: begin
               if (fr_ready) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // First beat is decoded for its length and kept whole for beat 3
   always_ff @(posedge inp) begin
      if (state == st_idle && in_hs) begin
         hold_q      <= first_w.raw;
         inner_len_q <= {first_w.hdr.total_len[7:0], first_w.hdr.total_len[15:8]};
         peer_q      <= ing_peer;
      end else if (state == st_payload && in_hs) begin
         hold_q <= ing_data;
         keep_q <= ing_keep;
      end
   end

   // ----------------------------------------------------------------------
   // Output beat
   // ----------------------------------------------------------------------
   always_comb begin
      fr_valid  = 1'b0;
      fr_data   = '0;
      fr_keep   = '1;
      fr_last   = 1'b0;
      ing_ready = 1'b0;
      case (state)
         st_idle, st_bypass: begin
            if (ing_bypass) begin
               fr_valid  = ing_valid;
               fr_data   = ing_data;
               fr_keep   = ing_keep;
               fr_last   = ing_last;
               ing_ready = fr_ready;
            end else begin
               ing_ready = 1'b1;
            end
         end
         st_hdr0: begin
            // DSCP, version/IHL, ethertype, source MAC, destination MAC
            fr_valid = 1'b1;
            fr_data  = {8'h00, 8'h45, eth_type[7:0], eth_type[15:8], local_mac, remote_mac};
         end
         st_hdr1: begin
            // Zero ID, flags and checksum
            fr_valid = 1'b1;
            fr_data  = {remote_ip[15:0], local_ip, 16'h0000, ip_proto, ip_ttl,
                        16'h0000, 16'h0000, ip_len[7:0], ip_len[15:8]};
         end
         st_hdr2: begin
            fr_valid = 1'b1;
            fr_data  = {remote_id[15:0], msg_type, 16'h0000, udp_len[7:0], udp_len[15:8],
                        remote_port, local_port, remote_ip[31:16]};
         end
         st_hdr3: begin
            // Counter, then the first inner bytes
            fr_valid = 1'b1;
            fr_data  = {hold_q[split-1:0], send_cnt, remote_id[31:16]};
         end
         st_payload: begin
            fr_valid  = ing_valid;
            fr_data   = {ing_data[split-1:0], hold_q[`WG_DATA_W-1:split]};
            fr_keep   = {ing_keep[head_bytes-1:0], {`WG_TAIL_BYTES{1'b1}}};
            fr_last   = ing_last & ~ing_keep[head_bytes];
            ing_ready = fr_ready;
         end
         st_flush: begin
            fr_valid = 1'b1;
            fr_data  = {{split{1'b0}}, hold_q[`WG_DATA_W-1:split]};
            fr_keep  = {{head_bytes{1'b0}}, keep_q[`WG_KEEP_W-1:head_bytes]};
            fr_last  = 1'b1;
         end
         default: begin
            fr_valid = 1'b0;
         end
      endcase
   end

endmodule

// File: design/wg_ingress.sv
`include "wg_encap_settings.svh"

module wg_ingress (
   input  logic                      inp,
   input  logic                      reset,
   input  logic                      in_valid,
   output logic                      in_ready,
   input  wg_encap_pkg::beat_t       in_data,
   input  logic [`WG_KEEP_W-1:0]     in_keep,
   input  logic                      in_last,
   input  logic [`WG_PEER_IDX_W-1:0] in_peer,
   input  logic                      in_bypass,
   output logic                      ing_valid,
   input  logic                      ing_ready,
   output wg_encap_pkg::beat_t       ing_data,
   output logic [`WG_KEEP_W-1:0]     ing_keep,
   output logic                      ing_last,
   output logic                      ing_sop,
   output logic [`WG_PEER_IDX_W-1:0] ing_peer,
   output logic                      ing_bypass
);

   // Next accepted beat opens a packet
   logic expect_sop;

   // Slot frees up in the same cycle the framer takes it
   assign in_ready = ~ing_valid | ing_ready;

   always_ff @(posedge inp) begin
      if (reset) begin
         ing_valid  <= 1'b0;
         expect_sop <= 1'b1;
      end else begin
         if (in_ready) begin
            ing_valid <= in_valid;
         end
         if (in_valid && in_ready) begin
            expect_sop <= in_last;
         end
      end
   end

   always_ff @(posedge inp) begin
      if (in_valid && in_ready) begin
         ing_data <= in_data;
         ing_keep <= in_keep;
         ing_last <= in_last;
         ing_sop  <= expect_sop;
         // Peer and bypass stick for the rest of the packet
         if (expect_sop) begin
            ing_peer   <= in_peer;
            ing_bypass <= in_bypass;
         end
      end
   end

   a_keep_nonzero: assert property (@(posedge inp) disable iff (reset)
      in_valid |-> (in_keep != '0));

endmodule

// File: design/wg_peer_table.sv
`include "wg_encap_settings.svh"

module wg_peer_table (
   input  logic                      inp,
   input  logic                      reset,
   input  logic                      cfg_write,
   input  logic [`WG_PEER_IDX_W-1:0] cfg_peer,
   input  logic [47:0]               cfg_local_mac,
   input  logic [47:0]               cfg_remote_mac,
   input  logic [31:0]               cfg_local_ip,
   input  logic [31:0]               cfg_remote_ip,
   input  logic [15:0]               cfg_local_port,
   input  logic [15:0]               cfg_remote_port,
   input  logic [31:0]               cfg_remote_id,
   input  logic [63:0]               cfg_send_cnt,
   input  logic                      lookup_req,
   input  logic [`WG_PEER_IDX_W-1:0] lookup_peer,
   input  logic                      count_advance,
   input  logic [`WG_PEER_IDX_W-1:0] count_peer,
   output logic [47:0]               local_mac,
   output logic [47:0]               remote_mac,
   output logic [31:0]               local_ip,
   output logic [31:0]               remote_ip,
   output logic [15:0]               local_port,
   output logic [15:0]               remote_port,
   output logic [31:0]               remote_id,
   output logic [63:0]               send_cnt
);

   // Record fields are kept in wire byte order, first byte in the low bits
   logic [47:0] local_mac_mem   [`WG_PEER_CNT];
   logic [47:0] remote_mac_mem  [`WG_PEER_CNT];
   logic [31:0] local_ip_mem    [`WG_PEER_CNT];
   logic [31:0] remote_ip_mem   [`WG_PEER_CNT];
   logic [15:0] local_port_mem  [`WG_PEER_CNT];
   logic [15:0] remote_port_mem [`WG_PEER_CNT];
   logic [31:0] remote_id_mem   [`WG_PEER_CNT];
   logic [63:0] send_cnt_mem    [`WG_PEER_CNT];

   always_ff @(posedge inp) begin
      if (cfg_write) begin
         local_mac_mem[cfg_peer]   <= cfg_local_mac;
         remote_mac_mem[cfg_peer]  <= cfg_remote_mac;
         local_ip_mem[cfg_peer]    <= cfg_local_ip;
         remote_ip_mem[cfg_peer]   <= cfg_remote_ip;
         local_port_mem[cfg_peer]  <= cfg_local_port;
         remote_port_mem[cfg_peer] <= cfg_remote_port;
         remote_id_mem[cfg_peer]   <= cfg_remote_id;
         send_cnt_mem[cfg_peer]    <= cfg_send_cnt;
      end
      // Counter steps in place once a data message has left
      if (count_advance) begin
         send_cnt_mem[count_peer] <= send_cnt_mem[count_peer] + 64'd1;
      end
   end

   // Registered read, fields are valid the cycle after the request
   always_ff @(posedge inp) begin
      if (lookup_req) begin
         local_mac   <= local_mac_mem[lookup_peer];
         remote_mac  <= remote_mac_mem[lookup_peer];
         local_ip    <= local_ip_mem[lookup_peer];
         remote_ip   <= remote_ip_mem[lookup_peer];
         local_port  <= local_port_mem[lookup_peer];
         remote_port <= remote_port_mem[lookup_peer];
         remote_id   <= remote_id_mem[lookup_peer];
         send_cnt    <= send_cnt_mem[lookup_peer];
      end
   end

   // Host writes and framer counter updates never hit the same record
   a_cfg_vs_count: assert property (@(posedge inp) disable iff (reset)
      !(count_advance && cfg_write && (count_peer == cfg_peer)));

endmodule

// File: tb.f
+incdir+design
+incdir+tests
design/wg_encap_pkg.sv
design/wg_peer_table.sv
design/wg_ingress.sv
design/wg_framer.sv
design/wg_egress.sv
design/wg_encap.sv
tests/wg_encap_tb.sv

// File: tests/wg_encap_model.svh
`ifndef WG_ENCAP_MODEL_SVH
`define WG_ENCAP_MODEL_SVH

// ----------------------------------------------------------------------
// Byte stream helpers
// ----------------------------------------------------------------------

// Field bytes in wire order, first byte from the low bits
task automatic append_field(input logic [63:0] value, input int count);
   int i;
   for (i = 0; i < count; i++) begin
      exp_bytes.push_back(value[8*i +: 8]);
   end
endtask

// Length fields go out big-endian
task automatic be16_field(input logic [15:0] value);
   exp_bytes.push_back(value[15:8]);
   exp_bytes.push_back(value[7:0]);
endtask

function automatic int count_beats(input int total);
   return (total + `WG_KEEP_W - 1) / `WG_KEEP_W;
endfunction

// Beat b of a byte stream, bytes past the end stay zero
function automatic beat_t beat_data(input logic [7:0] src[$], input int b);
   beat_t d;
   int    j;
   d = '0;
   for (j = 0; j < `WG_KEEP_W; j++) begin
      if (`WG_KEEP_W * b + j < src.size()) begin
         d[8*j +: 8] = src[`WG_KEEP_W * b + j];
      end
   end
   return d;
endfunction

function automatic logic [`WG_KEEP_W-1:0] keep_of(input int total, input int b);
   logic [`WG_KEEP_W-1:0] k;
   int                    j;
   k = '0;
   for (j = 0; j < `WG_KEEP_W; j++) begin
      k[j] = (`WG_KEEP_W * b + j < total);
   end
   return k;
endfunction

// ----------------------------------------------------------------------
// Expected output packet for one table row
// ----------------------------------------------------------------------
task automatic build_expected(input int row);
   int          peer;
   int          i;
   logic [15:0] ip_len;
   logic [15:0] udp_len;
   peer    = row_peer[row];
   ip_len  = 16'(row_len[row] + `WG_IP_HDR_BYTES + `WG_UDP_HDR_BYTES + `WG_WG_HDR_BYTES);
   udp_len = 16'(row_len[row] + `WG_UDP_HDR_BYTES + `WG_WG_HDR_BYTES);
   exp_bytes.delete();
   if (!row_bypass[row]) begin
      // Ethernet, destination first
      append_field(peer_remote_mac[peer], 6);
      append_field(peer_local_mac[peer], 6);
      be16_field(`WG_ETH_TYPE_IPV4);
      // IPv4 without options, zero checksum
      append_field(64'h0045, 2);
      be16_field(ip_len);
      append_field(64'h0, 4);
      append_field(`WG_IP_TTL, 1);
      append_field(`WG_IP_PROTO_UDP, 1);
      append_field(64'h0, 2);
      append_field(peer_local_ip[peer], 4);
      append_field(peer_remote_ip[peer], 4);
      // UDP
      append_field(peer_local_port[peer], 2);
      append_field(peer_remote_port[peer], 2);
      be16_field(udp_len);
      append_field(64'h0, 2);
      // Message type with three reserved bytes, receiver, counter
      append_field(`WG_MSG_TYPE_DATA, 4);
      append_field(peer_remote_id[peer], 4);
      append_field(model_cnt[peer], 8);
      model_cnt[peer] = model_cnt[peer] + 64'd1;
   end
   for (i = 0; i < inner_bytes.size(); i++) begin
      exp_bytes.push_back(inner_bytes[i]);
   end
endtask

`endif

// File: tests/wg_encap_tb.sv
`include "wg_encap_settings.svh"

module wg_encap_tb;
   import wg_encap_pkg::*;

   localparam int n_rows     = 12;
   localparam int beat_limit = 1000;
   localparam int idle_limit = 100;

   logic                      inp;
   logic                      reset;
   logic                      in_valid;
   logic                      in_ready;
   beat_t                     in_data;
   logic [`WG_KEEP_W-1:0]     in_keep;
   logic                      in_last;
   logic [`WG_PEER_IDX_W-1:0] in_peer;
   logic                      in_bypass;
   logic                      out_valid;
   logic                      out_ready;
   beat_t                     out_data;
   logic [`WG_KEEP_W-1:0]     out_keep;
   logic                      out_last;
   logic                      cfg_write;
   logic [`WG_PEER_IDX_W-1:0] cfg_peer;
   logic [47:0]               cfg_local_mac;
   logic [47:0]               cfg_remote_mac;
   logic [31:0]               cfg_local_ip;
   logic [31:0]               cfg_remote_ip;
   logic [15:0]               cfg_local_port;
   logic [15:0]               cfg_remote_port;
   logic [31:0]               cfg_remote_id;
   logic [63:0]               cfg_send_cnt;
   logic                      idle;

   // Peer records in wire byte order and the model's own counters
   logic [47:0] peer_local_mac   [`WG_PEER_CNT];
   logic [47:0] peer_remote_mac  [`WG_PEER_CNT];
   logic [31:0] peer_local_ip    [`WG_PEER_CNT];
   logic [31:0] peer_remote_ip   [`WG_PEER_CNT];
   logic [15:0] peer_local_port  [`WG_PEER_CNT];
   logic [15:0] peer_remote_port [`WG_PEER_CNT];
   logic [31:0] peer_remote_id   [`WG_PEER_CNT];
   logic [63:0] peer_start_cnt   [`WG_PEER_CNT];
   logic [63:0] model_cnt        [`WG_PEER_CNT];

   // ----------------------------------------------------------------------
   // Stimulus table with the hand-counted output beats of each row
   // ----------------------------------------------------------------------
   int row_peer   [n_rows] = '{0, 3, 3, 7, 0, 7, 3, 6, 0, 3, 6, 2};
   int row_len    [n_rows] = '{20, 22, 23, 33, 32, 38, 47, 48, 64, 75, 86, 90};
   bit row_bypass [n_rows] = '{0, 0, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0};
   int row_seed   [n_rows] = '{17, 90, 3, 201, 66, 128, 45, 7, 250, 31, 112, 180};
   int row_beats  [n_rows] = '{5, 5, 6, 3, 6, 6, 7, 3, 8, 9, 9, 10};

   logic [7:0]   inner_bytes [$];
   logic [7:0]   exp_bytes   [$];
   logic [255:0] stall_bits;
   logic [7:0]   cyc;
   bit           stall_en;

   wg_encap wg_encap_i (.*);

   `include "wg_encap_model.svh"

   always #50 inp = ~inp;

   // Output back-pressure from a fixed random pattern
   always @(posedge inp) begin
      if (reset) begin
         cyc       <= '0;
         out_ready <= 1'b1;
      end else begin
         cyc       <= cyc + 8'd1;
         out_ready <= ~(stall_en & stall_bits[cyc]);
      end
   end

   // ----------------------------------------------------------------------
   // Error reporting
   // ----------------------------------------------------------------------
   task automatic stop_run;
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [`WG_DATA_W-1:0] expected,
                                  input logic [`WG_DATA_W-1:0] actual);
      $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
      stop_run();
   endtask

   task automatic report_failure(input string what);
      $display("ERROR time %0t %s", $time, what);
      stop_run();
   endtask

   // ----------------------------------------------------------------------
   // Stimulus and monitor
   // ----------------------------------------------------------------------

   // Inner IPv4 packet with a short header and a fill pattern from the row seed
   task automatic build_inner(input int row);
      int          i;
      logic [15:0] len;
      logic [7:0]  fill;
      len = 16'(row_len[row]);
      inner_bytes.delete();
      inner_bytes.push_back(8'h45);
      inner_bytes.push_back(8'h00);
      inner_bytes.push_back(len[15:8]);
      inner_bytes.push_back(len[7:0]);
      for (i = 4; i < row_len[row]; i++) begin
         fill = 8'(row_seed[row] + i * 29 + (i >> 3));
         inner_bytes.push_back(fill);
      end
   endtask

   task automatic write_config;
      int p;
      for (p = 0; p < `WG_PEER_CNT; p++) begin
         @(posedge inp);
         cfg_write       <= 1'b1;
         cfg_peer        <= `WG_PEER_IDX_W'(p);
         cfg_local_mac   <= peer_local_mac[p];
         cfg_remote_mac  <= peer_remote_mac[p];
         cfg_local_ip    <= peer_local_ip[p];
         cfg_remote_ip   <= peer_remote_ip[p];
         cfg_local_port  <= peer_local_port[p];
         cfg_remote_port <= peer_remote_port[p];
         cfg_remote_id   <= peer_remote_id[p];
         cfg_send_cnt    <= peer_start_cnt[p];
         model_cnt[p] = peer_start_cnt[p];
      end
      @(posedge inp);
      cfg_write <= 1'b0;
   endtask

   // Each beat is held from a rising edge until in_ready
   task automatic drive_packet(input int row);
      int n;
      int b;
      int guard;
      n = count_beats(inner_bytes.size());
      for (b = 0; b < n; b++) begin
         in_valid  <= 1'b1;
         in_data   <= beat_data(inner_bytes, b);
         in_keep   <= keep_of(inner_bytes.size(), b);
         in_last   <= (b == n - 1);
         in_peer   <= `WG_PEER_IDX_W'(row_peer[row]);
         in_bypass <= row_bypass[row];
         guard = 0;
         @(negedge inp);
         while (!in_ready) begin
            guard++;
            assert (guard < beat_limit) else report_failure("input beat was never accepted");
            @(negedge inp);
         end
         @(posedge inp);
      end
      in_valid <= 1'b0;
      in_last  <= 1'b0;
   endtask

   task automatic collect_packet(input int row);
      int                    n;
      int                    b;
      int                    j;
      int                    guard;
      beat_t                 exp_d;
      beat_t                 mask;
      logic [`WG_KEEP_W-1:0] exp_k;
      n = row_beats[row];
      for (b = 0; b < n; b++) begin
         exp_d = beat_data(exp_bytes, b);
         exp_k = keep_of(exp_bytes.size(), b);
         for (j = 0; j < `WG_KEEP_W; j++) begin
            mask[8*j +: 8] = {8{exp_k[j]}};
         end
         guard = 0;
         @(negedge inp);
         while (!(out_valid && out_ready)) begin
            guard++;
            assert (guard < beat_limit) else report_failure("output beat did not arrive");
            @(negedge inp);
         end
         assert (out_keep === exp_k) else report_mismatch("out_keep", exp_k, out_keep);
         assert ((out_data & mask) === exp_d)
            else report_mismatch("out_data", exp_d, out_data & mask);
         assert (out_last === (b == n - 1)) else report_mismatch("out_last", b == n - 1, out_last);
      end
   endtask

   task automatic wait_idle;
      int guard;
      guard = 0;
      @(negedge inp);
      assert (!out_valid) else report_failure("output beat seen after the end of a packet");
      while (!idle) begin
         guard++;
         assert (guard < idle_limit) else report_failure("idle did not return after a packet");
         @(negedge inp);
      end
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      int          p;
      int          i;
      int          pass;
      int          r;
      void'($urandom(32'h1863_aed2));
      inp = 1'b0;
      reset = 1'b1;
      in_valid = 1'b0;
      in_data = '0;
      in_keep = '0;
      in_last = 1'b0;
      in_peer = '0;
      in_bypass = 1'b0;
      out_ready = 1'b1;
      cfg_write = 1'b0;
      cfg_peer = '0;
      cfg_local_mac = '0;
      cfg_remote_mac = '0;
      cfg_local_ip = '0;
      cfg_remote_ip = '0;
      cfg_local_port = '0;
      cfg_remote_port = '0;
      cfg_remote_id = '0;
      cfg_send_cnt = '0;
      stall_en = 1'b0;
      for (i = 0; i < 256; i++) begin
         stall_bits[i] = ($urandom % 3) == 0;
      end
      for (p = 0; p < `WG_PEER_CNT; p++) begin
         peer_local_mac[p]   = 48'({$urandom, $urandom});
         peer_remote_mac[p]  = 48'({$urandom, $urandom});
         peer_local_ip[p]    = $urandom;
         peer_remote_ip[p]   = $urandom;
         peer_local_port[p]  = 16'($urandom);
         peer_remote_port[p] = 16'($urandom);
         peer_remote_id[p]   = $urandom;
         peer_start_cnt[p]   = {$urandom, $urandom};
      end

      repeat (2) @(posedge inp);
      reset <= 1'b0;
      @(negedge inp);
      assert (idle === 1'b1) else report_failure("idle is low after reset");
      write_config();

      // Full speed first, then the same rows under random back-pressure
      for (pass = 0; pass < 2; pass++) begin
         @(negedge inp);
         stall_en = (pass == 1);
         for (r = 0; r < n_rows; r++) begin
            build_inner(r);
            build_expected(r);
            @(posedge inp);
            fork
               drive_packet(r);
               collect_packet(r);
            join
            wait_idle();
         end
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
